// File: source/exu_cfg.svh
//**************************************
// execution unit configuration
// data path, register index, commit tag
// and shift amount widths shared by the
// package and all execution-unit modules
//**************************************

`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// integer data path width
`define EXU_XLEN 32

// destination register index into the
// 32-entry integer register file
`define EXU_REG_ADDR_WIDTH 5

// tag that follows each instruction to commit
`define EXU_COMMIT_ID_WIDTH 3

// shift amount, low bits of op2
`define EXU_SHAMT_WIDTH 5

`endif

// File: source/exu_pkg.sv
//**************************************
// execution unit types
// operation encodings for the ALU, the
// multiplier and the branch unit, plus
// the issue and writeback structs
//**************************************

`include "exu_cfg.svh"

package exu_pkg;

    typedef enum logic [3:0] {
        alu_add      = 4'd0,
        alu_sub      = 4'd1,
        alu_sll      = 4'd2,
        alu_slt      = 4'd3,
        alu_sltu     = 4'd4,
        alu_xor      = 4'd5,
        alu_srl      = 4'd6,
        alu_sra      = 4'd7,
        alu_or       = 4'd8,
        alu_and      = 4'd9,
        // lui / auipc result already formed upstream
        alu_pass_op2 = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        mul_mul    = 2'd0,
        mul_mulh   = 2'd1,
        mul_mulhsu = 2'd2,
        mul_mulhu  = 2'd3
    } mul_op_e;

    typedef enum logic [2:0] {
        bru_beq  = 3'd0,
        bru_bne  = 3'd1,
        bru_blt  = 3'd2,
        bru_bltu = 3'd3,
        bru_bge  = 3'd4,
        bru_bgeu = 3'd5,
        bru_jal  = 3'd6,
        bru_jalr = 3'd7
    } bru_op_e;

    typedef struct packed {
        logic [`EXU_XLEN-1:0]            op1;
        logic [`EXU_XLEN-1:0]            op2;
        alu_op_e                         op;
        logic [`EXU_REG_ADDR_WIDTH-1:0]  rd;
        logic [`EXU_COMMIT_ID_WIDTH-1:0] commit_id;
        logic                            reg_we;
    } alu_req_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0]            op1;
        logic [`EXU_XLEN-1:0]            op2;
        mul_op_e                         op;
        logic [`EXU_REG_ADDR_WIDTH-1:0]  rd;
        logic [`EXU_COMMIT_ID_WIDTH-1:0] commit_id;
    } mul_req_t;

    // op1/op2 are compared, jump_op1 + jump_op2 is the target
    typedef struct packed {
        logic [`EXU_XLEN-1:0] op1;
        logic [`EXU_XLEN-1:0] op2;
        logic [`EXU_XLEN-1:0] jump_op1;
        logic [`EXU_XLEN-1:0] jump_op2;
        bru_op_e              op;
    } bru_req_t;

    // we high marks a valid register file write
    typedef struct packed {
        logic [`EXU_XLEN-1:0]            wdata;
        logic [`EXU_REG_ADDR_WIDTH-1:0]  waddr;
        logic [`EXU_COMMIT_ID_WIDTH-1:0] commit_id;
        logic                            we;
    } wb_t;

endpackage

// File: source/exu_alu.sv
//**************************************
// integer ALU lane
// single-cycle result into one output
// slot, held while writeback is not
// ready and flushed on interrupt
//**************************************

`include "exu_cfg.svh"

module exu_alu
    import exu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     int_assert_i,
    input  logic     req_alu_i,
    input  alu_req_t alu_req_i,
    input  logic     wb_ready_i,
    output wb_t      wb_o,
    output logic     alu_stall_o
);

    logic [`EXU_XLEN-1:0]        op1;
    logic [`EXU_XLEN-1:0]        op2;
    logic [`EXU_SHAMT_WIDTH-1:0] shamt;
    logic [`EXU_XLEN-1:0]        result;
    logic                        accept;

    // output slot
    logic                            slot_we_q;
    logic [`EXU_XLEN-1:0]            slot_wdata_q;
    logic [`EXU_REG_ADDR_WIDTH-1:0]  slot_waddr_q;
    logic [`EXU_COMMIT_ID_WIDTH-1:0] slot_cid_q;

    assign op1   = alu_req_i.op1;
    assign op2   = alu_req_i.op2;
    assign shamt = op2[`EXU_SHAMT_WIDTH-1:0];

    always_comb begin
        case (alu_req_i.op)
            alu_add:      result = op1 + op2;
            alu_sub:      result = op1 - op2;
            alu_sll:      result = op1 << shamt;
            alu_slt:      result = {{(`EXU_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            alu_sltu:     result = {{(`EXU_XLEN-1){1'b0}}, op1 < op2};
            alu_xor:      result = op1 ^ op2;
            alu_srl:      result = op1 >> shamt;
            // arithmetic shift keeps the sign of op1
            alu_sra:      result = $signed(op1) >>> shamt;
            alu_or:       result = op1 | op2;
            alu_and:      result = op1 & op2;
            alu_pass_op2: result = op2;
            default:      result = '0;
        endcase
    end

    // slot full and nobody draining it
    assign alu_stall_o = slot_we_q & ~wb_ready_i;

    // a draining slot can take the next request on the same edge
    assign accept = req_alu_i & ~alu_stall_o & ~int_assert_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_we_q <= 1'b0;
        end else if (int_assert_i) begin
            slot_we_q <= 1'b0;
        end else if (accept) begin
            // reg_we low still frees the slot
            slot_we_q <= alu_req_i.reg_we;
        end else if (wb_ready_i) begin
            slot_we_q <= 1'b0;
        end
    end

    // payload only moves on accept, so back-pressure holds it
    always_ff @(posedge clk) begin
        if (accept) begin
            slot_wdata_q <= result;
            slot_waddr_q <= alu_req_i.rd;
            slot_cid_q   <= alu_req_i.commit_id;
        end
    end

    always_comb begin
        wb_o.wdata     = slot_wdata_q;
        wb_o.waddr     = slot_waddr_q;
        wb_o.commit_id = slot_cid_q;
        wb_o.we        = slot_we_q;
    end

endmodule

// File: source/exu_mul.sv
//**************************************
// two-stage 32x32 multiplier
// stage one forms the full product,
// stage two picks the result word and
// holds it until writeback takes it
//**************************************

`include "exu_cfg.svh"

module exu_mul
    import exu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     int_assert_i,
    input  logic     req_mul_i,
    input  mul_req_t mul_req_i,
    input  logic     wb_ready_i,
    output wb_t      wb_o,
    output logic     mul_stall_o
);

    localparam int PROD_WIDTH = 2 * `EXU_XLEN;

    logic                         op1_signed;
    logic                         op2_signed;
    logic signed [`EXU_XLEN:0]    op1_ext;
    logic signed [`EXU_XLEN:0]    op2_ext;
    logic signed [PROD_WIDTH-1:0] product;
    logic                         advance;
    logic                         accept;

    // stage one
    logic                            s1_valid_q;
    logic [PROD_WIDTH-1:0]           s1_prod_q;
    logic                            s1_hi_q;
    logic [`EXU_REG_ADDR_WIDTH-1:0]  s1_rd_q;
    logic [`EXU_COMMIT_ID_WIDTH-1:0] s1_cid_q;

    // stage two, the writeback slot
    logic                            s2_valid_q;
    logic [`EXU_XLEN-1:0]            s2_wdata_q;
    logic [`EXU_REG_ADDR_WIDTH-1:0]  s2_rd_q;
    logic [`EXU_COMMIT_ID_WIDTH-1:0] s2_cid_q;

    // mulh treats both signed, mulhsu only op1
    assign op1_signed = (mul_req_i.op == mul_mulh) || (mul_req_i.op == mul_mulhsu);
    assign op2_signed = (mul_req_i.op == mul_mulh);

    assign op1_ext = {op1_signed & mul_req_i.op1[`EXU_XLEN-1], mul_req_i.op1};
    assign op2_ext = {op2_signed & mul_req_i.op2[`EXU_XLEN-1], mul_req_i.op2};

    // low 64 bits of the 33x33 signed product
    assign product = PROD_WIDTH'(op1_ext) * PROD_WIDTH'(op2_ext);

    // one freeze condition for both stages
    assign advance     = ~(s2_valid_q & ~wb_ready_i);
    assign mul_stall_o = ~advance;
    assign accept      = req_mul_i & advance & ~int_assert_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (int_assert_i) begin
            // drop everything in flight
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (advance) begin
            s1_valid_q <= accept;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_prod_q <= product;
            s1_hi_q   <= (mul_req_i.op != mul_mul);
            s1_rd_q   <= mul_req_i.rd;
            s1_cid_q  <= mul_req_i.commit_id;
        end
    end

    // low word for mul, high word for the mulh family
    always_ff @(posedge clk) begin
        if (advance && s1_valid_q) begin
            s2_wdata_q <= s1_hi_q ? s1_prod_q[PROD_WIDTH-1:`EXU_XLEN]
                                  : s1_prod_q[`EXU_XLEN-1:0];
            s2_rd_q    <= s1_rd_q;
            s2_cid_q   <= s1_cid_q;
        end
    end

    always_comb begin
        wb_o.wdata     = s2_wdata_q;
        wb_o.waddr     = s2_rd_q;
        wb_o.commit_id = s2_cid_q;
        wb_o.we        = s2_valid_q;
    end

endmodule

// File: source/exu_bru.sv
//**************************************
// branch unit
// resolves conditional branches and
// jumps in the same cycle, checks the
// target alignment, and lets an
// interrupt jump win over the redirect
//**************************************

`include "exu_cfg.svh"

module exu_bru
    import exu_pkg::*;
(
    input  logic                 req_bjp_i,
    input  bru_req_t             bru_req_i,
    input  logic                 int_jump_i,
    input  logic [`EXU_XLEN-1:0] int_addr_i,
    output logic                 jump_flag_o,
    output logic [`EXU_XLEN-1:0] jump_addr_o,
    output logic                 misaligned_fetch_o
);

    logic                 op_eq;
    logic                 op_lt;
    logic                 op_ltu;
    logic                 cond_met;
    logic                 taken;
    logic [`EXU_XLEN-1:0] target_sum;
    logic [`EXU_XLEN-1:0] target;

    assign op_eq  = (bru_req_i.op1 == bru_req_i.op2);
    assign op_lt  = ($signed(bru_req_i.op1) < $signed(bru_req_i.op2));
    assign op_ltu = (bru_req_i.op1 < bru_req_i.op2);

    always_comb begin
        case (bru_req_i.op)
            bru_beq:  cond_met = op_eq;
            bru_bne:  cond_met = ~op_eq;
            bru_blt:  cond_met = op_lt;
            bru_bltu: cond_met = op_ltu;
            bru_bge:  cond_met = ~op_lt;
            bru_bgeu: cond_met = ~op_ltu;
            // unconditional jumps
            bru_jal:  cond_met = 1'b1;
            bru_jalr: cond_met = 1'b1;
            default:  cond_met = 1'b0;
        endcase
    end

    assign taken = req_bjp_i & cond_met;

    assign target_sum = bru_req_i.jump_op1 + bru_req_i.jump_op2;

    // jalr drops bit 0 of the computed address
    always_comb begin
        target = target_sum;
        if (bru_req_i.op == bru_jalr) begin
            target[0] = 1'b0;
        end
    end

    // interrupt jump has priority over the branch
    assign jump_flag_o = taken | int_jump_i;
    assign jump_addr_o = int_jump_i ? int_addr_i : target;

    // no compressed support, so bit 1 set is a bad fetch
    assign misaligned_fetch_o = taken & ~int_jump_i & target[1];

endmodule

// File: source/exu_top.sv
//**************************************
// execution unit top
// two ALU lanes, one multiplier and one
// branch unit, with their stalls merged
// into a single stall flag
//**************************************

`include "exu_cfg.svh"

module exu_top
    import exu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 int_assert_i,
    input  logic                 int_jump_i,
    input  logic [`EXU_XLEN-1:0] int_addr_i,
    input  logic                 req_alu0_i,
    input  alu_req_t             alu0_req_i,
    input  logic                 alu0_wb_ready_i,
    input  logic                 req_alu1_i,
    input  alu_req_t             alu1_req_i,
    input  logic                 alu1_wb_ready_i,
    input  logic                 req_mul_i,
    input  mul_req_t             mul_req_i,
    input  logic                 mul_wb_ready_i,
    input  logic                 req_bjp_i,
    input  bru_req_t             bru_req_i,
    output wb_t                  alu0_wb_o,
    output wb_t                  alu1_wb_o,
    output wb_t                  mul_wb_o,
    output logic                 stall_flag_o,
    output logic                 jump_flag_o,
    output logic [`EXU_XLEN-1:0] jump_addr_o,
    output logic                 misaligned_fetch_o
);

    logic alu0_stall;
    logic alu1_stall;
    logic mul_stall;

    exu_alu u_alu0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .int_assert_i (int_assert_i),
        .req_alu_i    (req_alu0_i),
        .alu_req_i    (alu0_req_i),
        .wb_ready_i   (alu0_wb_ready_i),
        .wb_o         (alu0_wb_o),
        .alu_stall_o  (alu0_stall)
    );

    exu_alu u_alu1 (
        .clk          (clk),
        .reset_i      (reset_i),
        .int_assert_i (int_assert_i),
        .req_alu_i    (req_alu1_i),
        .alu_req_i    (alu1_req_i),
        .wb_ready_i   (alu1_wb_ready_i),
        .wb_o         (alu1_wb_o),
        .alu_stall_o  (alu1_stall)
    );

    exu_mul u_mul (
        .clk          (clk),
        .reset_i      (reset_i),
        .int_assert_i (int_assert_i),
        .req_mul_i    (req_mul_i),
        .mul_req_i    (mul_req_i),
        .wb_ready_i   (mul_wb_ready_i),
        .wb_o         (mul_wb_o),
        .mul_stall_o  (mul_stall)
    );

    exu_bru u_bru (
        .req_bjp_i          (req_bjp_i),
        .bru_req_i          (bru_req_i),
        .int_jump_i         (int_jump_i),
        .int_addr_i         (int_addr_i),
        .jump_flag_o        (jump_flag_o),
        .jump_addr_o        (jump_addr_o),
        .misaligned_fetch_o (misaligned_fetch_o)
    );

    // any blocked writeback holds the issue stage
    assign stall_flag_o = alu0_stall | alu1_stall | mul_stall;

endmodule

// File: verification/exu_tb.sv
//****************************************
// execution unit testbench
// directed tests of the ALU lanes, the
// multiplier, the branch unit, the stall
// flag and the interrupt flush
//****************************************

`include "exu_cfg.svh"

module exu_tb
    import exu_pkg::*;
();

    // the tests run for fewer than 400 cycles
    localparam int MAX_CYCLES = 2000;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 int_assert;
    logic                 int_jump;
    logic [`EXU_XLEN-1:0] int_addr;
    logic                 req_alu0;
    alu_req_t             alu0_req;
    logic                 alu0_ready;
    logic                 req_alu1;
    alu_req_t             alu1_req;
    logic                 alu1_ready;
    logic                 req_mul;
    mul_req_t             mul_req;
    logic                 mul_ready;
    logic                 req_bjp;
    bru_req_t             bru_req;
    wb_t                  alu0_wb;
    wb_t                  alu1_wb;
    wb_t                  mul_wb;
    logic                 stall_flag;
    logic                 jump_flag;
    logic [`EXU_XLEN-1:0] jump_addr;
    logic                 misaligned;
    logic [31:0]          seed = 32'h60a0c80a;
    int                   cycle_count = 0;

    exu_top i_dut (
        .clk                (clk),
        .reset_i            (reset),
        .int_assert_i       (int_assert),
        .int_jump_i         (int_jump),
        .int_addr_i         (int_addr),
        .req_alu0_i         (req_alu0),
        .alu0_req_i         (alu0_req),
        .alu0_wb_ready_i    (alu0_ready),
        .req_alu1_i         (req_alu1),
        .alu1_req_i         (alu1_req),
        .alu1_wb_ready_i    (alu1_ready),
        .req_mul_i          (req_mul),
        .mul_req_i          (mul_req),
        .mul_wb_ready_i     (mul_ready),
        .req_bjp_i          (req_bjp),
        .bru_req_i          (bru_req),
        .alu0_wb_o          (alu0_wb),
        .alu1_wb_o          (alu1_wb),
        .mul_wb_o           (mul_wb),
        .stall_flag_o       (stall_flag),
        .jump_flag_o        (jump_flag),
        .jump_addr_o        (jump_addr),
        .misaligned_fetch_o (misaligned)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("TB FAILED");
            $fatal(1, "timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] sign_fill;
        sh = b[4:0];
        // ones shifted in from the top when a is negative
        sign_fill = a[31] ? ~(32'hffffffff >> sh) : 32'h0;
        case (op)
            alu_add:      return a + b;
            alu_sub:      return a + ~b + 32'd1;
            alu_sll:      return a << sh;
            // flipping the sign bit turns a signed compare into an unsigned one
            alu_slt:      return {31'b0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};
            alu_sltu:     return {31'b0, a < b};
            alu_xor:      return a ^ b;
            alu_srl:      return a >> sh;
            alu_sra:      return (a >> sh) | sign_fill;
            alu_or:       return a | b;
            alu_and:      return a & b;
            alu_pass_op2: return b;
            default:      return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] mul_ref(mul_op_e op, logic [31:0] a, logic [31:0] b);
        logic [63:0] a_ext;
        logic [63:0] b_ext;
        logic [63:0] prod;
        a_ext = {32'h0, a};
        b_ext = {32'h0, b};
        if (op == mul_mulh || op == mul_mulhsu) begin
            a_ext[63:32] = {32{a[31]}};
        end
        if (op == mul_mulh) begin
            b_ext[63:32] = {32{b[31]}};
        end
        prod = a_ext * b_ext;
        return (op == mul_mul) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic logic bru_taken_ref(bru_op_e op, logic [31:0] a, logic [31:0] b);
        logic lt_s;
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            bru_beq:  return a == b;
            bru_bne:  return a != b;
            bru_blt:  return lt_s;
            bru_bltu: return a < b;
            bru_bge:  return !lt_s;
            bru_bgeu: return a >= b;
            // jal and jalr
            default:  return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] corner_value(int idx);
        case (idx % 4)
            0:       return 32'h80000000;
            1:       return 32'hffffffff;
            2:       return 32'h7fffffff;
            default: return 32'h00000001;
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_wb(input string name, input wb_t wb, input logic [31:0] data,
                            input logic [4:0] rd, input logic [2:0] cid);
        check_value({name, " we"}, 32'(wb.we), 32'd1);
        check_value({name, " wdata"}, wb.wdata, data);
        check_value({name, " waddr"}, 32'(wb.waddr), 32'(rd));
        check_value({name, " commit_id"}, 32'(wb.commit_id), 32'(cid));
    endtask

    task automatic test_reset();
        check_value("alu0 we after reset", 32'(alu0_wb.we), 32'd0);
        check_value("alu1 we after reset", 32'(alu1_wb.we), 32'd0);
        check_value("mul we after reset", 32'(mul_wb.we), 32'd0);
        check_value("stall_flag after reset", 32'(stall_flag), 32'd0);
        check_value("jump_flag after reset", 32'(jump_flag), 32'd0);
    endtask

    task automatic test_alu_ops();
        logic [31:0] exp0;
        logic [31:0] exp1;
        for (int i = 0; i <= int'(alu_pass_op2); i++) begin
            alu0_req = '{op1: next_rand(), op2: next_rand(), op: alu_op_e'(i),
                         rd: 5'(i), commit_id: 3'(i), reg_we: 1'b1};
            alu1_req = '{op1: next_rand(), op2: next_rand(), op: alu_op_e'(i),
                         rd: 5'(i + 16), commit_id: 3'(i + 4), reg_we: 1'b1};
            req_alu0 = 1'b1;
            req_alu1 = 1'b1;
            exp0 = alu_ref(alu0_req.op, alu0_req.op1, alu0_req.op2);
            exp1 = alu_ref(alu1_req.op, alu1_req.op1, alu1_req.op2);
            tick();
            check_wb("alu0", alu0_wb, exp0, alu0_req.rd, alu0_req.commit_id);
            check_wb("alu1", alu1_wb, exp1, alu1_req.rd, alu1_req.commit_id);
        end
        // accepted but nothing to write
        alu0_req.reg_we = 1'b0;
        alu1_req.reg_we = 1'b0;
        tick();
        check_value("alu0 we without reg_we", 32'(alu0_wb.we), 32'd0);
        check_value("alu1 we without reg_we", 32'(alu1_wb.we), 32'd0);
        req_alu0 = 1'b0;
        req_alu1 = 1'b0;
    endtask

    task automatic test_alu_backpressure();
        logic [31:0] held;
        logic [31:0] next_exp;
        alu0_ready = 1'b0;
        alu0_req = '{op1: next_rand(), op2: next_rand(), op: alu_xor,
                     rd: 5'd7, commit_id: 3'd1, reg_we: 1'b1};
        held = alu_ref(alu_xor, alu0_req.op1, alu0_req.op2);
        req_alu0 = 1'b1;
        tick();
        // next request waits at the input while the slot is blocked
        alu0_req = '{op1: next_rand(), op2: next_rand(), op: alu_sra,
                     rd: 5'd9, commit_id: 3'd2, reg_we: 1'b1};
        next_exp = alu_ref(alu_sra, alu0_req.op1, alu0_req.op2);
        repeat (4) begin
            check_wb("alu0 held", alu0_wb, held, 5'd7, 3'd1);
            check_value("stall_flag while alu0 blocked", 32'(stall_flag), 32'd1);
            tick();
        end
        // drain and refill on the same edge
        alu0_ready = 1'b1;
        #1;
        check_value("stall_flag with alu0 ready", 32'(stall_flag), 32'd0);
        tick();
        req_alu0 = 1'b0;
        check_wb("alu0 refill", alu0_wb, next_exp, 5'd9, 3'd2);
        tick();
        check_value("alu0 we after drain", 32'(alu0_wb.we), 32'd0);
    endtask

    task automatic test_mul_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 6; k++) begin
                a = (k < 4) ? corner_value(k) : next_rand();
                b = (k < 4) ? corner_value(k + 1) : next_rand();
                mul_req = '{op1: a, op2: b, op: mul_op_e'(i), rd: 5'(k), commit_id: 3'(k)};
                expected = mul_ref(mul_op_e'(i), a, b);
                req_mul = 1'b1;
                tick();
                req_mul = 1'b0;
                check_value("mul we one cycle after issue", 32'(mul_wb.we), 32'd0);
                tick();
                check_wb("mul", mul_wb, expected, 5'(k), 3'(k));
                tick();
            end
        end
    endtask

    task automatic test_mul_order();
        logic [31:0] first;
        logic [31:0] second;
        mul_ready = 1'b0;
        mul_req = '{op1: next_rand(), op2: next_rand(), op: mul_mulhu, rd: 5'd10, commit_id: 3'd2};
        first = mul_ref(mul_mulhu, mul_req.op1, mul_req.op2);
        req_mul = 1'b1;
        tick();
        mul_req = '{op1: next_rand(), op2: next_rand(), op: mul_mul, rd: 5'd11, commit_id: 3'd3};
        second = mul_ref(mul_mul, mul_req.op1, mul_req.op2);
        tick();
        req_mul = 1'b0;
        repeat (4) begin
            check_wb("mul first", mul_wb, first, 5'd10, 3'd2);
            check_value("stall_flag while mul blocked", 32'(stall_flag), 32'd1);
            tick();
        end
        mul_ready = 1'b1;
        tick();
        check_wb("mul second", mul_wb, second, 5'd11, 3'd3);
        tick();
        check_value("mul we after drain", 32'(mul_wb.we), 32'd0);
    endtask

    task automatic test_bru();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] target;
        logic        taken;
        req_bjp = 1'b1;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++) begin
                // equal, -1 vs 1, 1 vs -1, then a random pair
                a = (k == 3) ? next_rand() : ((k == 0) ? 32'd5 : corner_value(2 * k - 1));
                b = (k == 3) ? next_rand() : ((k == 0) ? 32'd5 : corner_value(5 - 2 * k));
                bru_req = '{op1: a, op2: b, jump_op1: next_rand() & 32'hfffffffc,
                            jump_op2: (next_rand() & 32'hfffffffc) | 32'(k), op: bru_op_e'(i)};
                #1;
                taken = bru_taken_ref(bru_op_e'(i), a, b);
                target = bru_req.jump_op1 + bru_req.jump_op2;
                if (bru_op_e'(i) == bru_jalr) begin
                    target = target & 32'hfffffffe;
                end
                check_value("jump_flag", 32'(jump_flag), 32'(taken));
                check_value("jump_addr", jump_addr, target);
                check_value("misaligned_fetch", 32'(misaligned), 32'(taken & target[1]));
                tick();
            end
        end
        // interrupt jump over a taken, misaligned jal
        bru_req = '{op1: 32'd0, op2: 32'd0, jump_op1: 32'h1000, jump_op2: 32'h2, op: bru_jal};
        int_jump = 1'b1;
        int_addr = next_rand() & 32'hfffffffc;
        #1;
        check_value("jump_flag with int_jump", 32'(jump_flag), 32'd1);
        check_value("jump_addr with int_jump", jump_addr, int_addr);
        check_value("misaligned_fetch with int_jump", 32'(misaligned), 32'd0);
        tick();
        // interrupt jump alone still redirects
        req_bjp = 1'b0;
        #1;
        check_value("jump_flag with only int_jump", 32'(jump_flag), 32'd1);
        check_value("jump_addr with only int_jump", jump_addr, int_addr);
        tick();
        int_jump = 1'b0;
        #1;
        check_value("jump_flag when idle", 32'(jump_flag), 32'd0);
        check_value("misaligned_fetch when idle", 32'(misaligned), 32'd0);
        tick();
    endtask

    task automatic test_interrupt();
        alu0_ready = 1'b0;
        alu0_req = '{op1: next_rand(), op2: next_rand(), op: alu_add,
                     rd: 5'd3, commit_id: 3'd5, reg_we: 1'b1};
        req_alu0 = 1'b1;
        tick();
        req_alu0 = 1'b0;
        mul_req = '{op1: next_rand(), op2: next_rand(), op: mul_mul, rd: 5'd4, commit_id: 3'd6};
        req_mul = 1'b1;
        tick();
        check_value("alu0 we before interrupt", 32'(alu0_wb.we), 32'd1);
        // requests on the flush edge are dropped too
        alu1_req = '{op1: next_rand(), op2: next_rand(), op: alu_or,
                     rd: 5'd8, commit_id: 3'd7, reg_we: 1'b1};
        req_alu1 = 1'b1;
        int_assert = 1'b1;
        tick();
        int_assert = 1'b0;
        req_alu1 = 1'b0;
        req_mul = 1'b0;
        repeat (4) begin
            check_value("alu0 we after interrupt", 32'(alu0_wb.we), 32'd0);
            check_value("alu1 we after interrupt", 32'(alu1_wb.we), 32'd0);
            check_value("mul we after interrupt", 32'(mul_wb.we), 32'd0);
            check_value("stall_flag after interrupt", 32'(stall_flag), 32'd0);
            tick();
        end
        alu0_ready = 1'b1;
    endtask

    initial begin
        reset = 1'b1;
        int_assert = 1'b0;
        int_jump = 1'b0;
        int_addr = '0;
        req_alu0 = 1'b0;
        alu0_req = '0;
        alu0_ready = 1'b1;
        req_alu1 = 1'b0;
        alu1_req = '0;
        alu1_ready = 1'b1;
        req_mul = 1'b0;
        mul_req = '0;
        mul_ready = 1'b1;
        req_bjp = 1'b0;
        bru_req = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset();
        test_alu_ops();
        test_alu_backpressure();
        test_mul_ops();
        test_mul_order();
        test_bru();
        test_interrupt();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: project.f
+incdir+source
source/exu_pkg.sv
source/exu_alu.sv
source/exu_mul.sv
source/exu_bru.sv
source/exu_top.sv
verification/exu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the execution unit testbench with Verilator and runs it
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary -f project.f --top-module exu_tb -Mdir obj_dir \
    && ./obj_dir/Vexu_tb \
    || { echo "simulation did not pass"; exit 1; }

echo "simulation passed"
